// ==== dv/tb_fifo_model.svh ====
// LFSR source, mask helper, accept prediction and queue reference model

// 32-bit Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// one LFSR step per bit taken
task automatic take_bits(input int n, output logic [31:0] val);
  val = '0;
  for (int i = 0; i < n; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    val = {val[30:0], lfsr_state[0]};
  end
endtask

// contiguous mask of w bits starting at bit 0
function automatic logic [WR_PORTS-1:0] width_mask(input int w);
  return WR_PORTS'((1 << w) - 1);
endfunction

// pops only see entries already stored
function automatic logic pop_allowed(input int used, input logic [RD_PORTS-1:0] pop_m);
  return $countones(pop_m) <= used;
endfunction

function automatic logic push_allowed(input int used, input logic [WR_PORTS-1:0] push_m,
                                      input logic [RD_PORTS-1:0] pop_m);
  int pops;
  pops = pop_allowed(used, pop_m) ? $countones(pop_m) : 0;
  return used - pops + $countones(push_m) <= int'(FIFO_DEPTH);
endfunction

// ==============================
// reference queue
// ==============================
logic [DATA_W-1:0] model_q [$];

// one clock edge: flush, then pops from old entries, then pushes
task automatic model_step();
  logic [RD_PORTS-1:0][DATA_W-1:0] rd;
  int pops;
  int pushes;
  rd = '0;
  if (flush) begin
    model_q.delete();
  end else begin
    pops   = pop_allowed(model_q.size(), pop) ? $countones(pop) : 0;
    pushes = push_allowed(model_q.size(), push, pop) ? $countones(push) : 0;
    for (int k = 0; k < pops; k++) begin
      rd[k] = model_q.pop_front();
    end
    for (int i = 0; i < pushes; i++) begin
      model_q.push_back(wdata[i]);
    end
  end
  exp_rdata <= rd;
  exp_usage <= CNT_W'(model_q.size());
endtask

// ==== dv/tb_multi_port_fifo.sv ====
// testbench: clock, reset, random stimulus, checking assertions, watchdog
`timescale 1ns/1ns

module tb_multi_port_fifo import mpfifo_pkg::*; ();

  localparam int          CLK_PERIOD = 40;
  localparam int          VAL_W      = RD_PORTS * DATA_W;
  localparam logic [31:0] LFSR_SEED  = 32'ha70e;
  // phase lengths in cycles
  localparam int RST_CYC   = 5;
  localparam int IDLE_CYC  = 4;
  localparam int BURST_CYC = 16;
  localparam int FILL_CYC  = 12;
  localparam int DRAIN_CYC = 14;
  localparam int MIX_CYC   = 40;
  localparam int FLUSH_CYC = 20;
  localparam int TOTAL_CYC = RST_CYC + IDLE_CYC + BURST_CYC + FILL_CYC + DRAIN_CYC
                           + MIX_CYC + FLUSH_CYC;

  logic                            clk, s_rst_n, flush;
  logic [WR_PORTS-1:0]             push;
  logic [WR_PORTS-1:0][DATA_W-1:0] wdata;
  logic [RD_PORTS-1:0]             pop;
  logic [RD_PORTS-1:0][DATA_W-1:0] rdata, exp_rdata;
  logic [CNT_W-1:0]                usage, exp_usage;
  logic                            full, empty, can_push, can_pop;
  logic                            exp_full, exp_empty, exp_can_push, exp_can_pop;
  logic [31:0]                     lfsr_state;

  `include "tb_fifo_model.svh"

  assign exp_full     = exp_usage == CNT_W'(FIFO_DEPTH);
  assign exp_empty    = exp_usage == '0;
  assign exp_can_pop  = pop_allowed(int'(exp_usage), pop);
  assign exp_can_push = push_allowed(int'(exp_usage), push, pop);

  multi_port_fifo u_dut (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .flush_i    (flush),
    .push_i     (push),
    .wdata_i    (wdata),
    .pop_i      (pop),
    .rdata_o    (rdata),
    .usage_o    (usage),
    .full_o     (full),
    .empty_o    (empty),
    .can_push_o (can_push),
    .can_pop_o  (can_pop)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      model_q.delete();
      exp_usage <= '0;
      exp_rdata <= '0;
    end else begin
      model_step();
    end
  end

  task automatic end_with_fail();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic value_fail(input string sig, input logic [VAL_W-1:0] exp_v,
                            input logic [VAL_W-1:0] act_v);
    $display("Fail at %0t ns: %s expected %0h, actual %0h", $time, sig, exp_v, act_v);
    end_with_fail();
  endtask

  // ==============================
  // checks
  // ==============================
  a_usage: assert property (@(posedge clk) disable iff (!s_rst_n) usage == exp_usage)
    else value_fail("usage_o", VAL_W'($sampled(exp_usage)), VAL_W'($sampled(usage)));
  a_full: assert property (@(posedge clk) disable iff (!s_rst_n) full == exp_full)
    else value_fail("full_o", VAL_W'($sampled(exp_full)), VAL_W'($sampled(full)));
  a_empty: assert property (@(posedge clk) disable iff (!s_rst_n) empty == exp_empty)
    else value_fail("empty_o", VAL_W'($sampled(exp_empty)), VAL_W'($sampled(empty)));
  a_rdata: assert property (@(posedge clk) disable iff (!s_rst_n) rdata == exp_rdata)
    else value_fail("rdata_o", VAL_W'($sampled(exp_rdata)), VAL_W'($sampled(rdata)));
  a_can_pop: assert property (@(posedge clk) disable iff (!s_rst_n) can_pop == exp_can_pop)
    else value_fail("can_pop_o", VAL_W'($sampled(exp_can_pop)), VAL_W'($sampled(can_pop)));
  a_can_push: assert property (@(posedge clk) disable iff (!s_rst_n) can_push == exp_can_push)
    else value_fail("can_push_o", VAL_W'($sampled(exp_can_push)), VAL_W'($sampled(can_push)));

  // random data on every write port, inputs change on the edge
  task automatic drive(input logic [WR_PORTS-1:0] push_m, input logic [RD_PORTS-1:0] pop_m,
                       input logic flush_v);
    logic [WR_PORTS-1:0][DATA_W-1:0] data;
    logic [31:0]                     r;
    for (int i = 0; i < WR_PORTS; i++) begin
      take_bits(DATA_W, r);
      data[i] = r;
    end
    @(posedge clk);
    push  <= push_m;
    wdata <= data;
    pop   <= pop_m;
    flush <= flush_v;
  endtask

  // width 1 to 4
  task automatic pick_width(output int w);
    logic [31:0] r;
    take_bits(2, r);
    w = int'(r[1:0]) + 1;
  endtask

  // ==============================
  // stimulus phases
  // ==============================
  initial begin
    int          w;
    int          v;
    logic [31:0] r;
    lfsr_state = LFSR_SEED;
    s_rst_n    = 1'b0;
    flush      = 1'b0;
    push       = '0;
    wdata      = '0;
    pop        = '0;
    repeat (RST_CYC) @(posedge clk);
    s_rst_n <= 1'b1;
    repeat (IDLE_CYC) drive('0, '0, 1'b0);
    // burst of pushes, then pops
    repeat (6) begin
      pick_width(w);
      drive(width_mask(w), '0, 1'b0);
    end
    repeat (BURST_CYC - 6) begin
      pick_width(w);
      drive('0, width_mask(w), 1'b0);
    end
    // pushes well past full
    repeat (FILL_CYC) begin
      pick_width(w);
      drive(width_mask(w), '0, 1'b0);
    end
    // drain into near-empty, single pushes now and then
    repeat (DRAIN_CYC) begin
      pick_width(w);
      take_bits(1, r);
      drive(width_mask(int'(r[0])), width_mask(w), 1'b0);
    end
    // refill, then push and pop together, often while full
    repeat (5) drive('1, '0, 1'b0);
    repeat (MIX_CYC - 5) begin
      pick_width(w);
      pick_width(v);
      drive(width_mask(w), width_mask(v), 1'b0);
    end
    // flush under load with a push and a pop in the same cycle
    repeat (3) drive('1, '0, 1'b0);
    drive('1, width_mask(2), 1'b1);
    repeat (FLUSH_CYC - 6) begin
      pick_width(w);
      pick_width(v);
      drive(width_mask(w), width_mask(v), 1'b0);
    end
    repeat (2) drive('0, '0, 1'b0);
    @(posedge clk);
    $display("TEST RESULT: PASS");
    $finish;
  end

  initial begin
    #((TOTAL_CYC + 100) * CLK_PERIOD);
    $display("watchdog timeout: stimulus did not finish in time");
    end_with_fail();
  end

endmodule

// ==== flist.f ====
+incdir+dv
hdl/mpfifo_pkg.sv
hdl/bank_if.sv
hdl/bank_ram.sv
hdl/mpfifo_ctrl.sv
hdl/rd_align.sv
hdl/multi_port_fifo.sv
dv/tb_multi_port_fifo.sv

// ==== hdl/bank_if.sv ====
// per-bank write/read address and data bundle between controller and bank array
`timescale 1ns/1ns

interface bank_if import mpfifo_pkg::*; ();

  // write side, one strobe per bank
  logic [BANK_NUM-1:0]              we;
  logic [BANK_NUM-1:0][BANK_AW-1:0] waddr;
  logic [BANK_NUM-1:0][DATA_W-1:0]  wdata;

  // read side, always the head of each bank
  logic [BANK_NUM-1:0][BANK_AW-1:0] raddr;

  // controller drives the whole bundle
  modport ctrl (
    output we,
    output waddr,
    output wdata,
    output raddr
  );

  // each bank picks out its own slot
  modport ram (
    input we,
    input waddr,
    input wdata,
    input raddr
  );

endinterface

// ==== hdl/bank_ram.sv ====
// single bank storage: simple dual-port, read-first, registered read
`timescale 1ns/1ns

module bank_ram import mpfifo_pkg::*; #(
  parameter int unsigned BANK_ID = 0
) (
  input  logic              clk,
  bank_if.ram               bus,
  output logic [DATA_W-1:0] rdata_o
);

  logic [DATA_W-1:0] mem [RAM_DEPTH];

  logic              wr_en;
  logic [BANK_AW-1:0] wr_addr;
  logic [BANK_AW-1:0] rd_addr;

  // this bank's slot of the shared bundle
  assign wr_en   = bus.we[BANK_ID];
  assign wr_addr = bus.waddr[BANK_ID];
  assign rd_addr = bus.raddr[BANK_ID];

  // ==============================
  // write port
  // ==============================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= bus.wdata[BANK_ID];
    end
  end

  // ==============================
  // read port
  // ==============================
  // same-edge write to rd_addr is not seen here (read-first)
  always_ff @(posedge clk) begin
    rdata_o <= mem[rd_addr];
  end

endmodule

// ==== hdl/mpfifo_ctrl.sv ====
// FIFO controller: accept rules, occupancy, bank pointers, write rotation, bank addressing
`timescale 1ns/1ns

module mpfifo_ctrl import mpfifo_pkg::*; (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic                            flush_i,
  input  logic [WR_PORTS-1:0]             push_i,
  input  logic [WR_PORTS-1:0][DATA_W-1:0] wdata_i,
  input  logic [RD_PORTS-1:0]             pop_i,
  output logic                            can_push_o,
  output logic                            can_pop_o,
  output logic [CNT_W-1:0]                usage_o,
  output logic                            full_o,
  output logic                            empty_o,
  output logic [BANK_SEL_W-1:0]           rbank_o,
  output logic                            pop_ok_o,
  bank_if.ctrl                            bus
);

  logic [CNT_W-1:0]                 usage_q, usage_d;
  logic [BANK_SEL_W-1:0]            wbank_q, wbank_d;
  logic [BANK_SEL_W-1:0]            rbank_q, rbank_d;
  logic [BANK_NUM-1:0][BANK_AW-1:0] head_q, head_d;
  logic [BANK_NUM-1:0][BANK_AW-1:0] tail_q, tail_d;

  logic [WCNT_W-1:0] push_cnt, push_acc;
  logic [RCNT_W-1:0] pop_cnt, pop_acc;
  logic [CNT_W:0]    room_need;
  logic              push_ok;
  logic              pop_ok;

  // bank address +1, wraps at RAM_DEPTH
  function automatic logic [BANK_AW-1:0] addr_inc(input logic [BANK_AW-1:0] addr);
    if (addr == BANK_AW'(RAM_DEPTH - 1)) begin
      return '0;
    end
    return addr + 1'b1;
  endfunction

  // ==============================
  // mask counts and accept rules
  // ==============================
  always_comb begin : count_masks
    push_cnt = '0;
    pop_cnt  = '0;
    for (int i = 0; i < WR_PORTS; i++) begin
      push_cnt = push_cnt + WCNT_W'(push_i[i]);
    end
    for (int k = 0; k < RD_PORTS; k++) begin
      pop_cnt = pop_cnt + RCNT_W'(pop_i[k]);
    end
  end

  // pops only take entries stored before this cycle
  assign can_pop_o = CNT_W'(pop_cnt) <= usage_q;
  assign pop_ok    = can_pop_o & (|pop_i);
  assign pop_acc   = pop_ok ? pop_cnt : '0;

  assign room_need  = (CNT_W + 1)'(usage_q) - (CNT_W + 1)'(pop_acc)
                    + (CNT_W + 1)'(push_cnt);
  assign can_push_o = room_need <= (CNT_W + 1)'(FIFO_DEPTH);
  assign push_ok    = can_push_o & (|push_i);
  assign push_acc   = push_ok ? push_cnt : '0;

  // ==============================
  // write rotation onto the banks
  // ==============================
  always_comb begin : write_rotate
    logic [BANK_SEL_W-1:0] b;
    bus.we    = '0;
    bus.waddr = tail_q;
    bus.wdata = '0;
    for (int i = 0; i < WR_PORTS; i++) begin
      b = bank_add(wbank_q, (BANK_SEL_W + 1)'(i));
      if (push_ok && push_i[i] && !flush_i) begin
        bus.we[b]    = 1'b1;
        bus.wdata[b] = wdata_i[i];
      end
    end
  end

  // reads always sit on the head of every bank
  assign bus.raddr = head_q;

  // ==============================
  // next state
  // ==============================
  always_comb begin : next_state
    logic [BANK_SEL_W-1:0] b;
    tail_d = tail_q;
    head_d = head_q;
    for (int j = 0; j < BANK_NUM; j++) begin
      if (bus.we[j]) begin
        tail_d[j] = addr_inc(tail_q[j]);
      end
    end
    // contiguous pops touch each bank at most once
    for (int k = 0; k < RD_PORTS; k++) begin
      b = bank_add(rbank_q, (BANK_SEL_W + 1)'(k));
      if (pop_ok && pop_i[k]) begin
        head_d[b] = addr_inc(head_q[b]);
      end
    end
    wbank_d = bank_add(wbank_q, (BANK_SEL_W + 1)'(push_acc));
    rbank_d = bank_add(rbank_q, (BANK_SEL_W + 1)'(pop_acc));
    usage_d = usage_q - CNT_W'(pop_acc) + CNT_W'(push_acc);
  end

  // flush wins over push and pop
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      usage_q <= '0;
      wbank_q <= '0;
      rbank_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else if (flush_i) begin
      usage_q <= '0;
      wbank_q <= '0;
      rbank_q <= '0;
      head_q  <= '0;
      tail_q  <= '0;
    end else begin
      usage_q <= usage_d;
      wbank_q <= wbank_d;
      rbank_q <= rbank_d;
      head_q  <= head_d;
      tail_q  <= tail_d;
    end
  end

  assign usage_o  = usage_q;
  assign full_o   = usage_q == CNT_W'(FIFO_DEPTH);
  assign empty_o  = usage_q == '0;
  assign rbank_o  = rbank_q;
  assign pop_ok_o = pop_ok;

endmodule

// ==== hdl/mpfifo_pkg.sv ====
// multi-port FIFO sizes, derived widths and bank pointer wrap function
package mpfifo_pkg;

  // ==============================
  // sizes
  // ==============================
  localparam int unsigned FIFO_DEPTH = 16;
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned WR_PORTS   = 4;
  localparam int unsigned RD_PORTS   = 4;

  // one bank per port on the wider side
  localparam int unsigned BANK_NUM   = (WR_PORTS > RD_PORTS) ? WR_PORTS : RD_PORTS;
  localparam int unsigned RAM_DEPTH  = (FIFO_DEPTH + BANK_NUM - 1) / BANK_NUM;

  // ==============================
  // derived widths
  // ==============================
  localparam int unsigned BANK_AW    = $clog2(RAM_DEPTH);
  localparam int unsigned BANK_SEL_W = $clog2(BANK_NUM);
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned WCNT_W     = $clog2(WR_PORTS + 1);
  localparam int unsigned RCNT_W     = $clog2(RD_PORTS + 1);

  // bank pointer plus offset, modulo BANK_NUM
  // offset never exceeds BANK_NUM, so one subtract is enough
  function automatic logic [BANK_SEL_W-1:0] bank_add(
    input logic [BANK_SEL_W-1:0] base,
    input logic [BANK_SEL_W:0]   offs
  );
    logic [BANK_SEL_W:0] sum;
    sum = {1'b0, base} + offs;
    if (sum >= BANK_NUM) begin
      sum = sum - (BANK_SEL_W + 1)'(BANK_NUM);
    end
    return sum[BANK_SEL_W-1:0];
  endfunction

endpackage

// ==== hdl/multi_port_fifo.sv ====
// multi-port FIFO top level: controller, bank array and read aligner
`timescale 1ns/1ns

module multi_port_fifo import mpfifo_pkg::*; (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic                            flush_i,
  input  logic [WR_PORTS-1:0]             push_i,
  input  logic [WR_PORTS-1:0][DATA_W-1:0] wdata_i,
  input  logic [RD_PORTS-1:0]             pop_i,
  output logic [RD_PORTS-1:0][DATA_W-1:0] rdata_o,
  output logic [CNT_W-1:0]                usage_o,
  output logic                            full_o,
  output logic                            empty_o,
  output logic                            can_push_o,
  output logic                            can_pop_o
);

  logic [BANK_SEL_W-1:0]           rbank;
  logic                            pop_ok;
  logic [BANK_NUM-1:0][DATA_W-1:0] bank_rdata;

  bank_if bank_bus ();

  // ==============================
  // pointers and accept logic
  // ==============================
  mpfifo_ctrl u_ctrl (
    .clk        (clk),
    .s_rst_n    (s_rst_n),
    .flush_i    (flush_i),
    .push_i     (push_i),
    .wdata_i    (wdata_i),
    .pop_i      (pop_i),
    .can_push_o (can_push_o),
    .can_pop_o  (can_pop_o),
    .usage_o    (usage_o),
    .full_o     (full_o),
    .empty_o    (empty_o),
    .rbank_o    (rbank),
    .pop_ok_o   (pop_ok),
    .bus        (bank_bus.ctrl)
  );

  // ==============================
  // bank array
  // ==============================
  for (genvar g = 0; g < BANK_NUM; g++) begin : g_bank
    bank_ram #(
      .BANK_ID (g)
    ) u_bank_ram (
      .clk     (clk),
      .bus     (bank_bus.ram),
      .rdata_o (bank_rdata[g])
    );
  end

  // read data lands one cycle after the pop
  rd_align u_rd_align (
    .clk          (clk),
    .s_rst_n      (s_rst_n),
    .flush_i      (flush_i),
    .pop_i        (pop_i),
    .pop_ok_i     (pop_ok),
    .rbank_i      (rbank),
    .bank_rdata_i (bank_rdata),
    .rdata_o      (rdata_o)
  );

endmodule

// ==== hdl/rd_align.sv ====
// read aligner: registers accepted pop mask and read bank, rotates bank data to read ports
`timescale 1ns/1ns

module rd_align import mpfifo_pkg::*; (
  input  logic                            clk,
  input  logic                            s_rst_n,
  input  logic                            flush_i,
  input  logic [RD_PORTS-1:0]             pop_i,
  input  logic                            pop_ok_i,
  input  logic [BANK_SEL_W-1:0]           rbank_i,
  input  logic [BANK_NUM-1:0][DATA_W-1:0] bank_rdata_i,
  output logic [RD_PORTS-1:0][DATA_W-1:0] rdata_o
);

  // pop mask and read bank pointer from the pop cycle
  logic [RD_PORTS-1:0]   pop_mask_q;
  logic [BANK_SEL_W-1:0] rbank_q;

  // ==============================
  // pop cycle capture
  // ==============================
  always_ff @(posedge clk or negedge s_rst_n) begin
    if (!s_rst_n) begin
      pop_mask_q <= '0;
      rbank_q    <= '0;
    end else if (flush_i) begin
      pop_mask_q <= '0;
      rbank_q    <= '0;
    end else begin
      // a rejected pop leaves all ports at zero
      pop_mask_q <= pop_ok_i ? pop_i : '0;
      rbank_q    <= rbank_i;
    end
  end

  // ==============================
  // rotation onto read ports
  // ==============================
  // port k gets the k-th bank after the old read pointer
  always_comb begin : rotate
    for (int k = 0; k < RD_PORTS; k++) begin
      if (pop_mask_q[k]) begin
        rdata_o[k] = bank_rdata_i[bank_add(rbank_q, (BANK_SEL_W + 1)'(k))];
      end else begin
        rdata_o[k] = '0;
      end
    end
  end

endmodule
